/* build.f */
source/sysCtlPkg.sv
source/sysCtlIf.sv
source/apbRegs.sv
source/taskTimer.sv
source/perfMeter.sv
source/sysCtlTop.sv
dv/sysCtlTb.sv

/* dv/sysCtlTb.sv */
`timescale 1ns/1ps

module sysCtlTb import sysCtlPkg::*; ();

	localparam int WINDOW_DEPTH = 64;
	// far longer than the whole test sequence
	localparam time WATCHDOG = 200us;

	logic CLK;
	logic RESETn;
	logic PSEL;
	logic PENABLE;
	logic PWRITE;
	logic [ADDR_W-1:0] PADDR;
	logic [DATA_W-1:0] PWDATA;
	logic [DATA_W-1:0] PRDATA;
	logic PREADY;
	logic PSLVERR;
	logic TCK;
	logic HALT;
	logic EMPTY;
	ivT IV;
	logic taskIntr;

	int errorCount = 0;
	int checkCount = 0;
	int intrCount = 0;
	int intrStart;
	int baseN;
	int winLen;
	int lim;
	int i;
	logic [31:0] r;
	ptrT expectedPtr [3] = '{16'd3, 16'd0, 16'd1};

	sysCtlTop #(
		.WINDOW_DEPTH(WINDOW_DEPTH)
	) dut_i (
		.CLK      (CLK),
		.RESETn   (RESETn),
		.PSEL     (PSEL),
		.PENABLE  (PENABLE),
		.PWRITE   (PWRITE),
		.PADDR    (PADDR),
		.PWDATA   (PWDATA),
		.PRDATA   (PRDATA),
		.PREADY   (PREADY),
		.PSLVERR  (PSLVERR),
		.TCK      (TCK),
		.HALT     (HALT),
		.EMPTY    (EMPTY),
		.IV       (IV),
		.taskIntr (taskIntr)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;
	end

	// task switch requests seen so far
	always @(posedge CLK) begin
		if (RESETn && taskIntr)
			intrCount++;
	end

	// ----------------------------------------------------------
	// concurrent checks
	// ----------------------------------------------------------
	readyHigh: assert property (@(posedge CLK) disable iff (!RESETn) PREADY)
	else begin
		errorCount++;
		$display("mismatch PREADY: got 0x%h, expected 0x1", PREADY);
	end

	intrOneCycle: assert property (@(posedge CLK) disable iff (!RESETn)
		taskIntr |=> !taskIntr)
	else begin
		errorCount++;
		$display("taskIntr stayed high for more than one cycle at %0t", $time);
	end

	errOnlyInAccess: assert property (@(posedge CLK) disable iff (!RESETn)
		!(PSEL && PENABLE) |-> !PSLVERR)
	else begin
		errorCount++;
		$display("PSLVERR high outside an access cycle at %0t", $time);
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	function automatic logic [ADDR_W-1:0] byteAddr(input regAddrE regAddr);
		return {2'b00, regAddr, 2'b00};
	endfunction

	// inputs change 1 ns after the rising edge
	task automatic stepCycles(input int n);
		repeat (n) @(posedge CLK);
		#1;
	endtask

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else begin
			errorCount++;
			$display("mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic writeReg(input logic [ADDR_W-1:0] addr, input logic [31:0] data,
		input logic expErr);
		logic err;
		stepCycles(1);
		PSEL = 1'b1;
		PWRITE = 1'b1;
		PADDR = addr;
		PWDATA = data;
		stepCycles(1);
		PENABLE = 1'b1;
		#4;
		err = PSLVERR;
		stepCycles(1);
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		checkValue("PSLVERR", 32'(err), 32'(expErr));
	endtask

	task automatic readCheck(input string name, input logic [ADDR_W-1:0] addr,
		input logic [31:0] exp, input logic expErr);
		logic [31:0] data;
		logic err;
		stepCycles(1);
		PSEL = 1'b1;
		PWRITE = 1'b0;
		PADDR = addr;
		stepCycles(1);
		PENABLE = 1'b1;
		#4;
		data = PRDATA;
		err = PSLVERR;
		stepCycles(1);
		PSEL = 1'b0;
		PENABLE = 1'b0;
		checkValue(name, data, exp);
		checkValue("PSLVERR", 32'(err), 32'(expErr));
	endtask

	// single TCK pulse, then three quiet cycles
	task automatic pulseTck();
		TCK = 1'b1;
		stepCycles(1);
		TCK = 1'b0;
		stepCycles(3);
	endtask

	task automatic waitForIntr(input int limit);
		int n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < limit) begin
			stepCycles(1);
			seen = taskIntr;
			n++;
		end
		assert (seen)
		else begin
			errorCount++;
			$display("no task switch request within %0d cycles", limit);
		end
	endtask

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial begin : mainSeq
		void'($urandom(40));
		RESETn = 1'b0;
		PSEL = 1'b0;
		PENABLE = 1'b0;
		PWRITE = 1'b0;
		PADDR = '0;
		PWDATA = '0;
		TCK = 1'b0;
		HALT = 1'b0;
		EMPTY = 1'b0;
		IV = '0;
		repeat (16) @(posedge CLK);
		#1;
		RESETn = 1'b1;

		// reset values
		checkValue("taskIntr", 32'(taskIntr), 32'h0);
		readCheck("PERF_LIMIT", byteAddr(PERF_LIMIT), 32'(WINDOW_DEPTH), 1'b0);
		readCheck("CTRL", byteAddr(CTRL), 32'h0, 1'b0);
		readCheck("TIMER_VALUE", byteAddr(TIMER_VALUE), 32'h0, 1'b0);

		// register access with random data
		for (i = 0; i < 4; i++) begin
			r = $urandom;
			writeReg(byteAddr(TIMER_BASE), r, 1'b0);
			readCheck("TIMER_BASE", byteAddr(TIMER_BASE), r & 32'h0000FFFF, 1'b0);
			r = $urandom;
			writeReg(byteAddr(TASK_PTR), r, 1'b0);
			readCheck("TASK_PTR", byteAddr(TASK_PTR), r, 1'b0);
			r = $urandom;
			writeReg(byteAddr(CTRL), r, 1'b0);
			readCheck("CTRL", byteAddr(CTRL), r & 32'hC0000000, 1'b0);
			lim = 1 + int'($urandom % 64);
			writeReg(byteAddr(PERF_LIMIT), 32'(lim), 1'b0);
			readCheck("PERF_LIMIT", byteAddr(PERF_LIMIT), 32'(lim), 1'b0);
		end
		writeReg(byteAddr(PERF_LIMIT), 32'h0, 1'b0);
		readCheck("PERF_LIMIT", byteAddr(PERF_LIMIT), 32'h1, 1'b0);
		writeReg(byteAddr(PERF_LIMIT), 32'd65, 1'b0);
		readCheck("PERF_LIMIT", byteAddr(PERF_LIMIT), 32'd64, 1'b0);
		writeReg(byteAddr(PERF_LIMIT), $urandom | 32'h100, 1'b0);
		readCheck("PERF_LIMIT", byteAddr(PERF_LIMIT), 32'd64, 1'b0);
		readCheck("undefined register", 8'h3C, 32'h0, 1'b1);
		writeReg(byteAddr(PERF_CUR), $urandom, 1'b1);

		// timer expiry after N ticks
		baseN = 3 + int'($urandom % 7);
		writeReg(byteAddr(CTRL), 32'h80000000, 1'b0);
		writeReg(byteAddr(TIMER_BASE), 32'(baseN), 1'b0);
		stepCycles(2);
		intrStart = intrCount;
		repeat (baseN) pulseTck();
		checkValue("task switch count", 32'(intrCount - intrStart), 32'h1);
		readCheck("TIMER_VALUE", byteAddr(TIMER_VALUE), 32'h0, 1'b0);

		// ticks during HALT are ignored
		writeReg(byteAddr(TIMER_BASE), 32'(baseN), 1'b0);
		stepCycles(2);
		readCheck("TIMER_VALUE", byteAddr(TIMER_VALUE), 32'(baseN), 1'b0);
		HALT = 1'b1;
		repeat (3) pulseTck();
		HALT = 1'b0;
		readCheck("TIMER_VALUE", byteAddr(TIMER_VALUE), 32'(baseN), 1'b0);

		// pointer 2, limit 4
		writeReg(byteAddr(TASK_PTR), 32'h00040002, 1'b0);
		readCheck("TASK_PTR", byteAddr(TASK_PTR), 32'h00040002, 1'b0);
		for (i = 0; i < 3; i++) begin
			writeReg(byteAddr(TIMER_BASE), 32'h1, 1'b0);
			stepCycles(2);
			TCK = 1'b1;
			stepCycles(1);
			TCK = 1'b0;
			waitForIntr(10);
			stepCycles(1);
			readCheck("TASK_PTR", byteAddr(TASK_PTR), {16'd4, expectedPtr[i]}, 1'b0);
		end

		// ----------------------------------------------------------
		// performance meter
		// ----------------------------------------------------------
		winLen = 8 + int'($urandom % 25);
		IV = 4'hB;
		writeReg(byteAddr(PERF_LIMIT), 32'(winLen), 1'b0);
		writeReg(byteAddr(PERF_RESTART), 32'h0, 1'b0);
		stepCycles(winLen + 10);
		readCheck("PERF_CUR", byteAddr(PERF_CUR), 32'(3 * winLen), 1'b0);
		IV = 4'h1;
		stepCycles(winLen + 10);
		readCheck("PERF_CUR", byteAddr(PERF_CUR), 32'(winLen), 1'b0);
		readCheck("PERF_MAX", byteAddr(PERF_MAX), 32'(3 * winLen), 1'b0);
		readCheck("PERF_MIN", byteAddr(PERF_MIN), 32'(winLen), 1'b0);

		// EMPTY gates samples unless masked
		EMPTY = 1'b1;
		IV = 4'hF;
		stepCycles(4);
		readCheck("PERF_CUR", byteAddr(PERF_CUR), 32'(winLen), 1'b0);
		stepCycles(20);
		readCheck("PERF_CUR", byteAddr(PERF_CUR), 32'(winLen), 1'b0);
		writeReg(byteAddr(CTRL), 32'hC0000000, 1'b0);
		stepCycles(winLen + 10);
		readCheck("PERF_CUR", byteAddr(PERF_CUR), 32'(4 * winLen), 1'b0);
		writeReg(byteAddr(CTRL), 32'h80000000, 1'b0);
		writeReg(byteAddr(PERF_RESTART), 32'h0, 1'b0);
		stepCycles(2);
		readCheck("PERF_CUR", byteAddr(PERF_CUR), 32'h0, 1'b0);
		readCheck("PERF_MIN", byteAddr(PERF_MIN), 32'h000FFFFF, 1'b0);
		readCheck("PERF_MAX", byteAddr(PERF_MAX), 32'h0, 1'b0);
		EMPTY = 1'b0;
		stepCycles(4);

		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : watchdog
		#WATCHDOG;
		errorCount++;
		$display("timeout, test sequence still running at %0t", $time);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* run.sh */
#!/bin/sh
# compile and run the system control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module sysCtlTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/VsysCtlTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

/* source/apbRegs.sv */
`timescale 1ns/1ps

module apbRegs import sysCtlPkg::*; #(
	parameter int WINDOW_DEPTH = 1024
) (
	input  logic              CLK,
	input  logic              RESETn,
	input  logic              PSEL,
	input  logic              PENABLE,
	input  logic              PWRITE,
	input  logic [ADDR_W-1:0] PADDR,
	input  logic [DATA_W-1:0] PWDATA,
	output logic [DATA_W-1:0] PRDATA,
	output logic              PREADY,
	output logic              PSLVERR,
	timerIf.regs              timer,
	perfIf.regs               meter
);

	localparam int LIMIT_W = $clog2(WINDOW_DEPTH + 1);

	regAddrE regAddr;
	logic access;
	logic writeStb;
	logic addrOk;
	logic readOnly;
	timerT baseReg;
	logic timerEnable;
	logic emptyMask;
	logic [LIMIT_W-1:0] limitReg;
	logic reloadPulse;
	logic ptrWritePulse;
	logic restartPulse;
	logic [DATA_W-1:0] ptrData;

	// window length kept within 1..WINDOW_DEPTH
	function automatic logic [LIMIT_W-1:0] clipLimit(input logic [DATA_W-1:0] value);
		if (value == '0)
			return LIMIT_W'(1);
		if (value > DATA_W'(WINDOW_DEPTH))
			return LIMIT_W'(WINDOW_DEPTH);
		return value[LIMIT_W-1:0];
	endfunction

	// ----------------------------------------------------------
	// decode and read mux
	// ----------------------------------------------------------
	always_comb begin
		regAddr = regAddrE'(PADDR[5:2]);
		addrOk = 1'b1;
		readOnly = 1'b0;
		PRDATA = '0;
		case (regAddr)
			TIMER_BASE:   PRDATA = DATA_W'(baseReg);
			TIMER_VALUE:  begin
				PRDATA = DATA_W'(timer.timerValue);
				readOnly = 1'b1;
			end
			TASK_PTR:     PRDATA = timer.ptrValue;
			CTRL:         PRDATA = {timerEnable, emptyMask, {(DATA_W - 2){1'b0}}};
			PERF_LIMIT:   PRDATA = DATA_W'(limitReg);
			PERF_CUR:     begin
				PRDATA = DATA_W'(meter.curCount);
				readOnly = 1'b1;
			end
			PERF_MIN:     begin
				PRDATA = DATA_W'(meter.minCount);
				readOnly = 1'b1;
			end
			PERF_MAX:     begin
				PRDATA = DATA_W'(meter.maxCount);
				readOnly = 1'b1;
			end
			PERF_RESTART: PRDATA = '0;
			default:      addrOk = 1'b0;
		endcase
		// upper address bits select nothing
		if (PADDR[ADDR_W-1:6] != '0) begin
			addrOk = 1'b0;
			PRDATA = '0;
		end
	end

	assign access = PSEL & PENABLE;
	assign writeStb = access & PWRITE & addrOk & ~readOnly;
	assign PSLVERR = access & (~addrOk | (PWRITE & readOnly));
	assign PREADY = 1'b1;

	// ----------------------------------------------------------
	// settings and strobes
	// ----------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			baseReg <= '0;
			timerEnable <= 1'b0;
			emptyMask <= 1'b0;
			limitReg <= LIMIT_W'(WINDOW_DEPTH);
			reloadPulse <= 1'b0;
			ptrWritePulse <= 1'b0;
			restartPulse <= 1'b0;
		end else begin
			reloadPulse <= writeStb && (regAddr == TIMER_BASE);
			ptrWritePulse <= writeStb && (regAddr == TASK_PTR);
			restartPulse <= writeStb && (regAddr == PERF_RESTART);
			if (writeStb) begin
				case (regAddr)
					TIMER_BASE: baseReg <= PWDATA[15:0];
					CTRL:       begin
						timerEnable <= PWDATA[DATA_W-1];
						emptyMask <= PWDATA[DATA_W-2];
					end
					PERF_LIMIT: limitReg <= clipLimit(PWDATA);
					default:    ;
				endcase
			end
		end
	end

	// pointer word goes out together with its strobe
	always_ff @(posedge CLK) begin
		if (writeStb && (regAddr == TASK_PTR))
			ptrData <= PWDATA;
	end

	assign timer.baseValue = baseReg;
	assign timer.reload = reloadPulse;
	assign timer.enable = timerEnable;
	assign timer.ptrWrite = ptrWritePulse;
	assign timer.ptrWriteData = ptrData;

	assign meter.windowLimit = countT'(limitReg);
	assign meter.emptyMask = emptyMask;
	assign meter.restart = restartPulse;

endmodule

/* source/perfMeter.sv */
`timescale 1ns/1ps

module perfMeter import sysCtlPkg::*; #(
	parameter int WINDOW_DEPTH = 1024
) (
	input  logic CLK,
	input  logic RESETn,
	input  logic EMPTY,
	input  logic HALT,
	input  ivT   IV,
	perfIf.meter ctl
);

	localparam int LIMIT_W = $clog2(WINDOW_DEPTH + 1);
	localparam int IDX_W = $clog2(WINDOW_DEPTH);

	ivT ram [WINDOW_DEPTH];
	logic [LIMIT_W-1:0] limit;
	logic [LIMIT_W-1:0] wrPtr;
	logic [LIMIT_W-1:0] wrNext;
	logic qualify;
	logic wrWrap;
	meterStateE state;
	// sample stage
	logic validA;
	logic dropA;
	logic fullA;
	ivT sampleA;
	logic [IDX_W-1:0] addrA;
	// ram stage
	logic validB;
	logic dropB;
	logic fullB;
	ivT sampleB;
	ivT oldB;
	// result stage
	countT sum;
	countT minCount;
	countT maxCount;
	logic winFull;

	assign limit = ctl.windowLimit[LIMIT_W-1:0];
	assign qualify = !(EMPTY || HALT) || ctl.emptyMask;
	assign wrNext = wrPtr + LIMIT_W'(1);
	assign wrWrap = (wrNext >= limit);

	// ----------------------------------------------------------
	// sample stage, window pointer and fill state
	// ----------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			state <= FILL;
			wrPtr <= '0;
			validA <= 1'b0;
			dropA <= 1'b0;
			fullA <= 1'b0;
		end else if (ctl.restart) begin
			state <= FILL;
			wrPtr <= '0;
			validA <= 1'b0;
		end else begin
			validA <= qualify;
			if (qualify) begin
				// slot holds the sample leaving the window once in RUN
				dropA <= (state == RUN);
				fullA <= (state == RUN) || wrWrap;
				wrPtr <= wrWrap ? '0 : wrNext;
				if (wrWrap)
					state <= RUN;
			end
		end
	end

	always_ff @(posedge CLK) begin
		sampleA <= popCount(IV);
		addrA <= wrPtr[IDX_W-1:0];
	end

	// read-first window ram, old sample comes out as the new one goes in
	always_ff @(posedge CLK) begin
		if (validA)
			ram[addrA] <= sampleA;
		oldB <= ram[addrA];
		sampleB <= sampleA;
	end

	always_ff @(posedge CLK) begin
		if (!RESETn || ctl.restart) begin
			validB <= 1'b0;
			dropB <= 1'b0;
			fullB <= 1'b0;
		end else begin
			validB <= validA;
			dropB <= dropA;
			fullB <= fullA;
		end
	end

	// ----------------------------------------------------------
	// running sum and extremes
	// ----------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			sum <= '0;
			minCount <= '0;
			maxCount <= '0;
			winFull <= 1'b0;
		end else if (ctl.restart) begin
			sum <= '0;
			minCount <= '1;
			maxCount <= '0;
			winFull <= 1'b0;
		end else begin
			if (validB) begin
				sum <= sum + countT'(sampleB) - (dropB ? countT'(oldB) : countT'(0));
				if (fullB)
					winFull <= 1'b1;
			end
			// extremes only over complete windows
			if (winFull) begin
				if (sum < minCount)
					minCount <= sum;
				if (sum > maxCount)
					maxCount <= sum;
			end
		end
	end

	assign ctl.curCount = sum;
	assign ctl.minCount = minCount;
	assign ctl.maxCount = maxCount;

endmodule

/* source/sysCtlIf.sv */
`timescale 1ns/1ps

// ----------------------------------------------------------
// register block to task timer
// ----------------------------------------------------------
interface timerIf import sysCtlPkg::*; ();
	timerT baseValue;
	logic reload;
	logic enable;
	logic ptrWrite;
	// pointer in [15:0], wrap limit in [31:16]
	logic [DATA_W-1:0] ptrWriteData;
	timerT timerValue;
	logic [DATA_W-1:0] ptrValue;

	modport regs (
		output baseValue, reload, enable, ptrWrite, ptrWriteData,
		input  timerValue, ptrValue
	);

	modport timer (
		input  baseValue, reload, enable, ptrWrite, ptrWriteData,
		output timerValue, ptrValue
	);
endinterface

// ----------------------------------------------------------
// register block to performance meter
// ----------------------------------------------------------
interface perfIf import sysCtlPkg::*; ();
	countT windowLimit;
	logic emptyMask;
	logic restart;
	countT curCount;
	countT minCount;
	countT maxCount;

	modport regs (
		output windowLimit, emptyMask, restart,
		input  curCount, minCount, maxCount
	);

	modport meter (
		input  windowLimit, emptyMask, restart,
		output curCount, minCount, maxCount
	);
endinterface

/* source/sysCtlPkg.sv */
package sysCtlPkg;

	// bus widths
	localparam int DATA_W = 32;
	localparam int ADDR_W = 8;

	typedef logic [15:0] timerT;
	typedef logic [15:0] ptrT;
	typedef logic [19:0] countT;
	typedef logic [3:0] ivT;

	// word addresses, taken from PADDR[5:2]
	typedef enum logic [3:0] {
		TIMER_BASE   = 4'd0,
		TIMER_VALUE  = 4'd1,
		TASK_PTR     = 4'd2,
		CTRL         = 4'd3,
		PERF_LIMIT   = 4'd4,
		PERF_CUR     = 4'd5,
		PERF_MIN     = 4'd6,
		PERF_MAX     = 4'd7,
		PERF_RESTART = 4'd8
	} regAddrE;

	typedef enum logic {
		FILL = 1'b0,
		RUN  = 1'b1
	} meterStateE;

	// number of retired instructions in one IV word
	function automatic ivT popCount(input ivT lanes);
		ivT total;
		total = '0;
		for (int i = 0; i < $bits(ivT); i++)
			total = total + ivT'(lanes[i]);
		return total;
	endfunction

endpackage

/* source/sysCtlTop.sv */
`timescale 1ns/1ps

module sysCtlTop import sysCtlPkg::*; #(
	parameter int WINDOW_DEPTH = 1024
) (
	input  logic              CLK,
	input  logic              RESETn,
	// APB slave
	input  logic              PSEL,
	input  logic              PENABLE,
	input  logic              PWRITE,
	input  logic [ADDR_W-1:0] PADDR,
	input  logic [DATA_W-1:0] PWDATA,
	output logic [DATA_W-1:0] PRDATA,
	output logic              PREADY,
	output logic              PSLVERR,
	// core status
	input  logic              TCK,
	input  logic              HALT,
	input  logic              EMPTY,
	input  ivT                IV,
	output logic              taskIntr
);

	timerIf timerBus ();
	perfIf perfBus ();

	apbRegs #(
		.WINDOW_DEPTH(WINDOW_DEPTH)
	) regs_i (
		.CLK     (CLK),
		.RESETn  (RESETn),
		.PSEL    (PSEL),
		.PENABLE (PENABLE),
		.PWRITE  (PWRITE),
		.PADDR   (PADDR),
		.PWDATA  (PWDATA),
		.PRDATA  (PRDATA),
		.PREADY  (PREADY),
		.PSLVERR (PSLVERR),
		.timer   (timerBus.regs),
		.meter   (perfBus.regs)
	);

	taskTimer timer_i (
		.CLK      (CLK),
		.RESETn   (RESETn),
		.TCK      (TCK),
		.HALT     (HALT),
		.taskIntr (taskIntr),
		.ctl      (timerBus.timer)
	);

	perfMeter #(
		.WINDOW_DEPTH(WINDOW_DEPTH)
	) meter_i (
		.CLK    (CLK),
		.RESETn (RESETn),
		.EMPTY  (EMPTY),
		.HALT   (HALT),
		.IV     (IV),
		.ctl    (perfBus.meter)
	);

endmodule

/* source/taskTimer.sv */
`timescale 1ns/1ps

module taskTimer import sysCtlPkg::*; (
	input  logic  CLK,
	input  logic  RESETn,
	input  logic  TCK,
	input  logic  HALT,
	output logic  taskIntr,
	timerIf.timer ctl
);

	timerT value;
	logic reloadFlag;
	logic countFlag;
	ptrT ptr;
	ptrT ptrLimit;
	ptrT ptrNext;

	// next task table entry, wraps at the limit
	always_comb begin
		ptrNext = ptr + ptrT'(1);
		if (ptrNext == ptrLimit)
			ptrNext = '0;
	end

	// ----------------------------------------------------------
	// countdown
	// ----------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			reloadFlag <= 1'b0;
			countFlag <= 1'b0;
			value <= '0;
			taskIntr <= 1'b0;
		end else begin
			reloadFlag <= ctl.reload;
			countFlag <= TCK && ctl.enable && !HALT && (value != '0);
			if (reloadFlag)
				value <= ctl.baseValue;
			else if (countFlag && (value != '0))
				value <= value - timerT'(1);
			// request on the step from 1 to 0
			taskIntr <= countFlag && !reloadFlag && (value == timerT'(1));
		end
	end

	// ----------------------------------------------------------
	// task table pointer
	// ----------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			ptr <= '0;
			ptrLimit <= '0;
		end else if (ctl.ptrWrite) begin
			ptr <= ctl.ptrWriteData[15:0];
			ptrLimit <= ctl.ptrWriteData[31:16];
		end else if (taskIntr) begin
			ptr <= ptrNext;
		end
	end

	assign ctl.timerValue = value;
	assign ctl.ptrValue = {ptrLimit, ptr};

endmodule
